// File: Bender.yml
package:
  name: irq_subsys

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - irq_pkg.sv
      - irq_controller.sv
      - irq_csr.sv
      - irq_timer.sv
      - irq_trap_sequencer.sv
      - irq_subsys_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - irq_checker.sv
      - irq_tb.sv

// File: irq_checker.sv
/*
 * Concurrent assertions on the interrupt subsystem top level:
 * trap pulse width, handler exclusion, cause range and reset state
 */

`timescale 1ns/1ps

`include "irq_defines.svh"

module irq_checker (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              trap_i,          // Top level trap pulse
  input  logic              in_handler_i,
  input  irq_pkg::irq_id_t  trap_cause_i
);

  localparam irq_pkg::irq_vec_t impl_mask = `IRQ_MASK;

  logic              cause_ok;               // Cause names an implemented line
  int unsigned       fail_cnt = 0;           // Polled by the testbench

  assign cause_ok  = impl_mask[trap_cause_i];

  // Trap entry is a single-cycle pulse
  a_trap_pulse: assert property (@(posedge clk) disable iff (!rst_n) trap_i |=> !trap_i)
    else begin
      $error("trap pulse longer than one cycle");
      fail_cnt = fail_cnt + 1;
    end

  // Handler never leads straight into a new trap
  a_no_nested: assert property (@(posedge clk) disable iff (!rst_n) in_handler_i |=> !trap_i)
    else begin
      $error("trap raised while in the handler");
      fail_cnt = fail_cnt + 1;
    end

  a_cause_impl: assert property (@(posedge clk) disable iff (!rst_n) trap_i |-> cause_ok)
    else begin
      $error("trap cause is not an implemented interrupt");
      fail_cnt = fail_cnt + 1;
    end

  // No trap on the edge after reset release, MIE starts clear
  a_reset_quiet: assert property (@(posedge clk) $rose(rst_n) |=> !trap_i)
    else begin
      $error("trap high right after reset");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind irq_subsys_top irq_checker chk0 (
  .clk, .rst_n, .trap_i(trap_o), .in_handler_i(in_handler_o), .trap_cause_i(trap_cause_o)
);

// File: irq_controller.sv
/*
 * Interrupt controller: registers and masks the lines,
 * publishes mip, qualifies with mie and global MIE,
 * fixed priority encoder and unregistered wake-up level
 */

`timescale 1ns/1ps

`include "irq_defines.svh"

module irq_controller (
  input  logic               clk,
  input  logic               rst_n,

  // Interrupt sources
  input  irq_pkg::irq_vec_t  irq_i,       // External level interrupts
  input  logic               mti_i,       // Timer level, replaces line 7

  // From the CSR block
  input  irq_pkg::irq_vec_t  mie_i,       // Local enables
  input  logic               m_ie_i,      // Global machine enable

  // To the trap sequencer / CSR view
  output irq_pkg::irq_req_t  irq_req_o,
  output irq_pkg::irq_vec_t  mip_o,
  output logic               wakeup_o
);

  irq_pkg::irq_vec_t irq_lines;           // Lines with the timer merged in
  irq_pkg::irq_vec_t irq_q;               // Registered pending vector
  irq_pkg::irq_vec_t irq_qual;            // Pending and locally enabled
  irq_pkg::irq_id_t  irq_id;              // Encoder result

  ////////////////////////////////////////
  // Line merge and pending register
  ////////////////////////////////////////

  // Timer owns bit 7, the external line there is dropped
  always_comb begin
    irq_lines                 = irq_i;
    irq_lines[`IRQ_MTI_BIT]   = mti_i;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_q <= '0;
    end else begin
      irq_q <= irq_lines & `IRQ_MASK;     // Unimplemented bits never set
    end
  end

  assign mip_o    = irq_q;                // mip is the pending register itself
  assign irq_qual = irq_q & mie_i;

  // No clock needed to see a wake-up, so use the raw lines
  assign wakeup_o = |(irq_lines & `IRQ_MASK & mie_i);

  ////////////////////////////////////////
  // Priority encoder
  ////////////////////////////////////////

  // Later assignments win, so lowest priority comes first
  always_comb begin
    irq_id = '0;                                            // Default, value unused
    if (irq_qual[`IRQ_MTI_BIT]) begin
      irq_id = irq_pkg::irq_id_t'(`IRQ_MTI_BIT);            // MTI lowest
    end
    if (irq_qual[`IRQ_MSI_BIT]) begin
      irq_id = irq_pkg::irq_id_t'(`IRQ_MSI_BIT);            // MSI over MTI
    end
    if (irq_qual[`IRQ_MEI_BIT]) begin
      irq_id = irq_pkg::irq_id_t'(`IRQ_MEI_BIT);            // MEI over MSI
    end
    // Custom lines beat the standard ones, 31 is highest
    for (int i = 16; i < `IRQ_NUM_W; i++) begin
      if (irq_qual[i]) begin
        irq_id = irq_pkg::irq_id_t'(i);
      end
    end
  end

  // Request needs a local enable and the global enable
  assign irq_req_o.req = (|irq_qual) && m_ie_i;
  assign irq_req_o.id  = irq_id;

endmodule

// File: irq_csr.sv
/*
 * Machine CSR state: mie, mstatus MIE/MPIE, mcause
 * Decodes the CSR write strobe and forwards timer compare writes
 */

`timescale 1ns/1ps

`include "irq_defines.svh"

module irq_csr (
  input  logic                clk,
  input  logic                rst_n,

  input  irq_pkg::csr_wr_t    csr_wr_i,   // Software write command
  input  logic                take_i,     // Trap entry pulse
  input  logic                ret_i,      // Trap return pulse
  input  irq_pkg::irq_id_t    cause_i,    // Id of the trap being taken

  output irq_pkg::irq_vec_t   mie_o,
  output logic                m_ie_o,
  output irq_pkg::irq_id_t    mcause_o,
  output logic                cmp_we_o,   // To the timer
  output irq_pkg::irq_time_t  cmp_data_o
);

  irq_pkg::irq_vec_t mie_q;
  logic              m_ie_q;              // mstatus.MIE
  logic              m_pie_q;             // mstatus.MPIE
  irq_pkg::irq_id_t  mcause_q;
  logic              wr_mstatus;
  logic              wr_mie;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  assign wr_mstatus = csr_wr_i.we && (csr_wr_i.addr == irq_pkg::CSR_MSTATUS);
  assign wr_mie     = csr_wr_i.we && (csr_wr_i.addr == irq_pkg::CSR_MIE);
  assign cmp_we_o   = csr_wr_i.we && (csr_wr_i.addr == irq_pkg::CSR_MTIMECMP);
  assign cmp_data_o = csr_wr_i.data;      // Timer owns the compare register

  // Local enables, only implemented bits stick
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q <= '0;
    end else if (wr_mie) begin
      mie_q <= csr_wr_i.data & `IRQ_MASK;
    end
  end

  ////////////////////////////////////////
  // mstatus and mcause
  ////////////////////////////////////////

  // Trap entry and return win over a software mstatus write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_ie_q   <= 1'b0;
      m_pie_q  <= 1'b0;
      mcause_q <= '0;
    end else if (take_i) begin
      m_pie_q  <= m_ie_q;                 // Save, then mask further traps
      m_ie_q   <= 1'b0;
      mcause_q <= cause_i;
    end else if (ret_i) begin
      m_ie_q   <= m_pie_q;                // Restore previous enable
      m_pie_q  <= 1'b1;
    end else if (wr_mstatus) begin
      m_ie_q   <= csr_wr_i.data[3];       // MIE sits at bit 3
    end
  end

  assign mie_o    = mie_q;
  assign m_ie_o   = m_ie_q;
  assign mcause_o = mcause_q;

endmodule

// File: irq_defines.svh
/*
 * Interrupt subsystem widths, implemented interrupt mask
 * and the standard machine-mode interrupt bit positions
 */

`ifndef IRQ_DEFINES_SVH
`define IRQ_DEFINES_SVH

// Vector and id widths
`define IRQ_NUM_W   32                    // One bit per interrupt line
`define IRQ_ID_W    5                     // Enough to name any of the 32 lines
`define IRQ_TIME_W  32                    // mtime / mtimecmp width

////////////////////////////////////////
// Implemented interrupts
// Custom lines 31..16 plus MEI, MTI, MSI
// Everything else reads as zero
////////////////////////////////////////
`define IRQ_MASK    32'hFFFF_0888

// Standard machine-mode bit positions
`define IRQ_MEI_BIT 11                    // Machine external
`define IRQ_MSI_BIT 3                     // Machine software
`define IRQ_MTI_BIT 7                     // Machine timer

`endif

// File: irq_pkg.sv
/*
 * Shared types of the interrupt subsystem:
 * vector, id and time typedefs, CSR address and FSM enums,
 * CSR write command and interrupt request structs
 */

`include "irq_defines.svh"

package irq_pkg;

  // Plain vectors with a meaning
  typedef logic [`IRQ_NUM_W-1:0]  irq_vec_t;   // One bit per interrupt line
  typedef logic [`IRQ_ID_W-1:0]   irq_id_t;    // Interrupt number
  typedef logic [`IRQ_TIME_W-1:0] irq_time_t;  // Timer value

  // CSRs reachable through the write strobe
  typedef enum logic [1:0] {
    CSR_MSTATUS  = 2'd0,                       // Only MIE is writable
    CSR_MIE      = 2'd1,                       // Local enables
    CSR_MTIMECMP = 2'd2                        // Timer compare
  } csr_addr_e;

  // Trap sequencer states
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,                         // Waiting for a qualified request
    ST_TAKE    = 2'd1,                         // One-cycle trap entry
    ST_HANDLER = 2'd2,                         // Running the handler
    ST_RETURN  = 2'd3                          // One-cycle mret processing
  } trap_state_e;

  ////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////

  // One CSR write command, we is a single-cycle strobe
  typedef struct packed {
    logic        we;
    csr_addr_e   addr;
    logic [31:0] data;
  } csr_wr_t;

  // Controller to sequencer request
  typedef struct packed {
    logic    req;                              // Qualified interrupt pending
    irq_id_t id;                               // Winning interrupt
  } irq_req_t;

endpackage

// File: irq_subsys_top.sv
/*
 * Interrupt subsystem top level
 * Connects controller, CSR block, timer and trap sequencer
 */

`timescale 1ns/1ps

module irq_subsys_top (
  input  logic               clk,
  input  logic               rst_n,

  input  irq_pkg::irq_vec_t  irq_i,        // External level interrupts
  input  irq_pkg::csr_wr_t   csr_wr_i,     // CSR write command
  input  logic               mret_i,       // Return from handler

  output logic               trap_o,
  output irq_pkg::irq_id_t   trap_cause_o,
  output logic               in_handler_o,
  output irq_pkg::irq_vec_t  mip_o,
  output irq_pkg::irq_id_t   mcause_o,
  output logic               wakeup_o
);

  irq_pkg::irq_req_t  irq_req;             // Controller to sequencer
  irq_pkg::irq_vec_t  mie;
  logic               m_ie;
  logic               take;
  logic               ret;
  logic               cmp_we;              // CSR to timer
  irq_pkg::irq_time_t cmp_data;
  logic               mti;

  ////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////

  irq_controller ctrl0 (
    .clk, .rst_n, .irq_i, .mti_i(mti), .mie_i(mie), .m_ie_i(m_ie),
    .irq_req_o(irq_req), .mip_o, .wakeup_o
  );

  irq_csr csr0 (
    .clk, .rst_n, .csr_wr_i, .take_i(take), .ret_i(ret), .cause_i(trap_cause_o),
    .mie_o(mie), .m_ie_o(m_ie), .mcause_o, .cmp_we_o(cmp_we), .cmp_data_o(cmp_data)
  );

  irq_timer timer0 (
    .clk, .rst_n, .cmp_we_i(cmp_we), .cmp_data_i(cmp_data), .mti_o(mti)
  );

  // Sequencer cause feeds mcause on the take pulse
  irq_trap_sequencer seq0 (
    .clk, .rst_n, .irq_req_i(irq_req), .mret_i,
    .take_o(take), .ret_o(ret), .trap_o, .trap_cause_o, .in_handler_o
  );

endmodule

// File: irq_tb.sv
/*
 * Testbench for the interrupt subsystem: clock, reset, stimulus,
 * priority reference model, compare tasks, trap monitor and watchdog
 */

`timescale 1ns/1ps

`include "irq_defines.svh"

module irq_tb;

  localparam int N_MIP       = 16;            // Pending register vectors
  localparam int N_QUIET     = 8;             // No-trap vectors per case
  localparam int N_TRAP      = 24;            // Random trap vectors
  localparam int N_TIMER     = 20;            // Compare offset from mtime
  localparam int TIMEOUT_CYC = (N_MIP + 2 * N_QUIET + N_TRAP + 2) * 64;
  localparam irq_pkg::irq_vec_t EXT_MASK = `IRQ_MASK & ~(32'd1 << `IRQ_MTI_BIT);

  logic               clk;
  logic               rst_n;
  irq_pkg::irq_vec_t  irq_i;
  irq_pkg::csr_wr_t   csr_wr_i;
  logic               mret_i;
  logic               trap_o;
  irq_pkg::irq_id_t   trap_cause_o;
  logic               in_handler_o;
  irq_pkg::irq_vec_t  mip_o;
  irq_pkg::irq_id_t   mcause_o;
  logic               wakeup_o;

  logic               trap_ok;                // A trap may come now
  irq_pkg::irq_id_t   exp_id;                 // Cause of the next trap
  irq_pkg::irq_time_t mtime_ref;              // Model of the free-running timer
  int                 trap_cnt = 0;
  int                 err_count = 0;

  irq_subsys_top dut0 (
    .clk, .rst_n, .irq_i, .csr_wr_i, .mret_i,
    .trap_o, .trap_cause_o, .in_handler_o, .mip_o, .mcause_o, .wakeup_o
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;                    // 125 MHz
  end

  // mtime counts from zero every cycle out of reset
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mtime_ref <= '0;
    end else begin
      mtime_ref <= mtime_ref + 1'b1;
    end
  end

  ////////////////////////////////////////
  // Reference and checks
  ////////////////////////////////////////

  // Custom lines 31..16 first, then MEI, MSI, MTI
  function automatic irq_pkg::irq_id_t ref_id(input irq_pkg::irq_vec_t pend,
                                               input irq_pkg::irq_vec_t en);
    irq_pkg::irq_vec_t q;
    irq_pkg::irq_id_t  id;
    logic              found;
    q     = pend & en & `IRQ_MASK;
    id    = '0;
    found = 1'b0;
    for (int i = `IRQ_NUM_W - 1; i >= 16; i--) begin
      if (q[i] && !found) begin
        id    = irq_pkg::irq_id_t'(i);
        found = 1'b1;
      end
    end
    if (!found) begin
      if (q[`IRQ_MEI_BIT]) id = irq_pkg::irq_id_t'(`IRQ_MEI_BIT);
      else if (q[`IRQ_MSI_BIT]) id = irq_pkg::irq_id_t'(`IRQ_MSI_BIT);
      else if (q[`IRQ_MTI_BIT]) id = irq_pkg::irq_id_t'(`IRQ_MTI_BIT);
    end
    return id;
  endfunction

  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic fail_with(input string msg);
    err_count++;
    $display("%s", msg);
    abort_run();
  endtask

  task automatic check_id(input string name, input irq_pkg::irq_id_t got,
                          input irq_pkg::irq_id_t exp);
    if (got !== exp) begin
      err_count++;
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_vec(input string name, input irq_pkg::irq_vec_t got,
                           input irq_pkg::irq_vec_t exp);
    if (got !== exp) begin
      err_count++;
      $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_count++;
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // Trap monitor, every pulse must be expected and carry the right id
  always @(negedge clk) begin
    if (rst_n && trap_o) begin
      if (!trap_ok) fail_with("A trap was taken where none was expected");
      check_id("trap_cause_o", trap_cause_o, exp_id);
      trap_cnt++;
    end
    if (dut0.chk0.fail_cnt != 0) fail_with("An assertion in the checker failed");
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk);
    fail_with("Timeout, the tests did not finish in the expected time");
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic csr_write(input irq_pkg::csr_addr_e addr, input logic [31:0] data);
    @(negedge clk);
    csr_wr_i.we   = 1'b1;
    csr_wr_i.addr = addr;
    csr_wr_i.data = data;
    @(negedge clk);
    csr_wr_i.we   = 1'b0;                     // Strobe lasts one edge
  endtask

  task automatic wait_trap(output int cycles);
    cycles = 0;
    while (!trap_o && cycles < 40) begin
      @(negedge clk);
      cycles++;
    end
    if (!trap_o) fail_with("trap_o did not rise while a trap was expected");
  endtask

  task automatic end_handler();
    @(negedge clk);
    mret_i = 1'b1;
    @(negedge clk);
    mret_i = 1'b0;
    repeat (2) @(negedge clk);                // RETURN then back to IDLE
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    irq_pkg::irq_vec_t v;
    irq_pkg::irq_vec_t m;
    int                c;
    void'($urandom(32'h7c66_259a));
    rst_n    = 1'b0;
    irq_i    = '0;
    csr_wr_i = '0;
    mret_i   = 1'b0;
    trap_ok  = 1'b0;
    exp_id   = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // mip is last cycle's lines, timer idle so bit 7 stays low
    for (int i = 0; i < N_MIP; i++) begin
      @(negedge clk);
      v     = $urandom;
      irq_i = v;
      @(negedge clk);
      check_vec("mip_o", mip_o, v & EXT_MASK);
    end
    irq_i = '0;
    // MIE clear after reset, wake-up still follows the enabled lines
    for (int i = 0; i < N_QUIET; i++) begin
      m = $urandom;
      csr_write(irq_pkg::CSR_MIE, m);
      @(negedge clk);
      v     = $urandom;
      irq_i = v;
      #1;
      check_bit("wakeup_o", wakeup_o, |(v & m & EXT_MASK));
      repeat (3) @(negedge clk);
      irq_i = '0;
      repeat (2) @(negedge clk);
    end
    // MIE set but nothing qualified
    csr_write(irq_pkg::CSR_MSTATUS, 32'h8);
    for (int i = 0; i < N_QUIET; i++) begin
      m = $urandom;
      csr_write(irq_pkg::CSR_MIE, m);
      @(negedge clk);
      v     = irq_pkg::irq_vec_t'($urandom) & ~m;
      irq_i = v;
      #1;
      check_bit("wakeup_o", wakeup_o, 1'b0);
      repeat (3) @(negedge clk);
      irq_i = '0;
      repeat (2) @(negedge clk);
    end
    // Random traps, two cycles from the lines to the pulse
    for (int i = 0; i < N_TRAP; i++) begin
      m = $urandom;
      v = $urandom;
      if ((v & m & EXT_MASK) == '0) begin
        v[`IRQ_MEI_BIT] = 1'b1;               // Force one qualified line
        m[`IRQ_MEI_BIT] = 1'b1;
      end
      csr_write(irq_pkg::CSR_MIE, m);
      @(negedge clk);
      irq_i   = v;
      exp_id  = ref_id(v & EXT_MASK, m);
      trap_ok = 1'b1;
      wait_trap(c);
      if (c != 2) fail_with($sformatf("Trap came after %0d cycles instead of 2", c));
      @(negedge clk);
      trap_ok = 1'b0;
      irq_i   = '0;
      check_id("mcause_o", mcause_o, exp_id);
      check_bit("in_handler_o", in_handler_o, 1'b1);
      end_handler();
    end
    // Requests in the handler wait for mret, then the winner is taken
    csr_write(irq_pkg::CSR_MIE, `IRQ_MASK);
    @(negedge clk);
    irq_i   = 32'h0001_0000;
    exp_id  = irq_pkg::irq_id_t'(16);
    trap_ok = 1'b1;
    wait_trap(c);
    @(negedge clk);
    trap_ok = 1'b0;
    v       = 32'h0011_0800;                  // Lines 20, 16 and MEI
    irq_i   = v;
    repeat (6) begin
      @(negedge clk);
      check_bit("in_handler_o", in_handler_o, 1'b1);
    end
    check_vec("mip_o", mip_o, v & EXT_MASK);
    exp_id  = ref_id(v & EXT_MASK, `IRQ_MASK);
    trap_ok = 1'b1;
    mret_i  = 1'b1;
    @(negedge clk);
    mret_i  = 1'b0;
    wait_trap(c);
    @(negedge clk);
    trap_ok = 1'b0;
    irq_i   = '0;
    check_id("mcause_o", mcause_o, exp_id);
    end_handler();
    // Timer: compare at mtime + N, trap N + 2 cycles after the write edge
    csr_write(irq_pkg::CSR_MIE, 32'd1 << `IRQ_MTI_BIT);
    exp_id  = irq_pkg::irq_id_t'(`IRQ_MTI_BIT);
    trap_ok = 1'b1;
    @(negedge clk);
    csr_wr_i.we   = 1'b1;
    csr_wr_i.addr = irq_pkg::CSR_MTIMECMP;
    csr_wr_i.data = mtime_ref + N_TIMER;
    @(negedge clk);
    csr_wr_i.we   = 1'b0;
    wait_trap(c);
    if (c != N_TIMER + 2) begin
      fail_with($sformatf("Timer trap after %0d cycles, expected %0d", c, N_TIMER + 2));
    end
    @(negedge clk);
    trap_ok = 1'b0;
    check_id("mcause_o", mcause_o, exp_id);
    csr_write(irq_pkg::CSR_MTIMECMP, '1);
    repeat (2) @(negedge clk);
    check_vec("mip_o", mip_o, '0);            // MTI gone from mip
    end_handler();
    repeat (4) @(negedge clk);
    if (trap_cnt != N_TRAP + 3) begin
      fail_with($sformatf("Saw %0d traps, expected %0d", trap_cnt, N_TRAP + 3));
    end
    if (err_count == 0) begin
      $display("No errors");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

// File: irq_timer.sv
/*
 * Machine timer: free-running mtime, mtimecmp register
 * and the registered timer interrupt level
 */

`timescale 1ns/1ps

module irq_timer (
  input  logic                clk,
  input  logic                rst_n,

  input  logic                cmp_we_i,   // Compare write strobe
  input  irq_pkg::irq_time_t  cmp_data_i, // New compare value

  output logic                mti_o       // Timer interrupt level
);

  irq_pkg::irq_time_t mtime_q;
  irq_pkg::irq_time_t mtimecmp_q;
  logic               mti_q;

  ////////////////////////////////////////
  // Counter and compare
  ////////////////////////////////////////

  // Counts every cycle from zero, wraps silently
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  // All ones keeps the timer quiet out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mtimecmp_q <= '1;
    end else if (cmp_we_i) begin
      mtimecmp_q <= cmp_data_i;
    end
  end

  // Level, stays up until compare moves past mtime
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mti_q <= 1'b0;
    end else begin
      mti_q <= (mtime_q >= mtimecmp_q);
    end
  end

  assign mti_o = mti_q;

endmodule

// File: irq_trap_sequencer.sv
/*
 * Trap sequencer FSM: takes a qualified request,
 * pulses the trap for one cycle, holds the handler state
 * and processes the return strobe
 */

`timescale 1ns/1ps

module irq_trap_sequencer (
  input  logic               clk,
  input  logic               rst_n,

  input  irq_pkg::irq_req_t  irq_req_i,   // From the controller
  input  logic               mret_i,      // Handler done

  output logic               take_o,      // To CSR, trap entry
  output logic               ret_o,       // To CSR, trap return
  output logic               trap_o,      // One-cycle trap pulse
  output irq_pkg::irq_id_t   trap_cause_o,
  output logic               in_handler_o
);

  irq_pkg::trap_state_e state_q;
  irq_pkg::trap_state_e state_d;
  irq_pkg::irq_id_t     cause_q;          // Id latched on entry

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      irq_pkg::ST_IDLE: begin
        if (irq_req_i.req) begin
          state_d = irq_pkg::ST_TAKE;     // Request only looked at here
        end
      end
      irq_pkg::ST_TAKE: begin
        state_d = irq_pkg::ST_HANDLER;    // Always one cycle
      end
      irq_pkg::ST_HANDLER: begin
        if (mret_i) begin
          state_d = irq_pkg::ST_RETURN;
        end
      end
      irq_pkg::ST_RETURN: begin
        state_d = irq_pkg::ST_IDLE;       // MIE restored on this edge
      end
      default: begin
        state_d = irq_pkg::ST_IDLE;
      end
    endcase
  end

  ////////////////////////////////////////
  // State and cause registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= irq_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Cause held for the whole trap, later requests cannot disturb it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cause_q <= '0;
    end else if ((state_q == irq_pkg::ST_IDLE) && irq_req_i.req) begin
      cause_q <= irq_req_i.id;
    end
  end

  // Outputs are pure state decodes
  assign trap_o       = (state_q == irq_pkg::ST_TAKE);
  assign take_o       = (state_q == irq_pkg::ST_TAKE);     // Same cycle as trap
  assign ret_o        = (state_q == irq_pkg::ST_RETURN);
  assign in_handler_o = (state_q == irq_pkg::ST_HANDLER);
  assign trap_cause_o = cause_q;

endmodule

// File: list.f
+incdir+.
irq_pkg.sv
irq_controller.sv
irq_csr.sv
irq_timer.sv
irq_trap_sequencer.sv
irq_subsys_top.sv
irq_checker.sv
irq_tb.sv
